// ==== src/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Cache geometry
////////////////////////////////////////////////////////////////////////////

// Address split, high to low: tag | set index | word offset | byte
`define ICACHE_TAG_W 22
`define ICACHE_IDX_W 4
`define ICACHE_OFF_W 4

// Four ways of sixteen sets
`define ICACHE_WAYS 4
`define ICACHE_SETS 16

// Sixteen 32-bit words per line
`define ICACHE_LINE_WORDS 16
`define ICACHE_WORD_W 32

`endif

// ==== src/icache_pkg.sv ====
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  // Plain vectors
  typedef logic [`ICACHE_WORD_W-1:0] word_t;
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_IDX_W-1:0] index_t;
  typedef logic [`ICACHE_OFF_W-1:0] offset_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] age_t;
  typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

  // Whole line, word 0 in the low bits
  typedef word_t [`ICACHE_LINE_WORDS-1:0] line_t;

  typedef struct packed {
    tag_t tag;
    index_t index;
  } line_addr_t;

  // One word coming back from memory
  typedef struct packed {
    offset_t offset;
    word_t data;
  } fill_word_t;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_LOOKUP,
    CTRL_REFILL,
    CTRL_INSTALL,
    CTRL_REPLY
  } ctrl_state_t;

  typedef enum logic {
    RF_IDLE,
    RF_FETCH
  } refill_state_t;

endpackage

`default_nettype wire

// ==== src/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_ctrl (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               req,
  input  icache_pkg::word_t       insaddr,
  output icache_pkg::word_t       ins,
  output logic                    ok,
  output logic                    refill_start,
  output icache_pkg::line_addr_t  refill_line,
  input  wire logic               line_full,
  input  icache_pkg::line_t       fill_line,
  output logic                    line_take,
  output icache_pkg::index_t      lookup_idx,
  output icache_pkg::tag_t        lookup_tag,
  input  wire logic               hit,
  input  icache_pkg::way_t        hit_way,
  input  icache_pkg::way_t        victim_way,
  input  icache_pkg::line_t       read_line,
  output logic                    install,
  output icache_pkg::way_t        install_way,
  output icache_pkg::line_addr_t  install_line_addr,
  output icache_pkg::line_t       install_data,
  output logic                    touch,
  output icache_pkg::way_t        touch_way
);

  localparam int LINE_ADDR_W = $bits(icache_pkg::line_addr_t);
  localparam int BYTE_W = `ICACHE_WORD_W - LINE_ADDR_W - `ICACHE_OFF_W;

  icache_pkg::ctrl_state_t state;
  icache_pkg::line_addr_t  req_line;
  icache_pkg::offset_t     req_off;
  icache_pkg::way_t        victim_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= icache_pkg::CTRL_IDLE;
      ok <= 1'b0;
      victim_q <= '0;
    end
    else
    begin
      ok <= 1'b0;
      case (state)
        icache_pkg::CTRL_IDLE:
          if (req)
            state <= icache_pkg::CTRL_LOOKUP;
        icache_pkg::CTRL_LOOKUP:
          if (hit)
          begin
            state <= icache_pkg::CTRL_REPLY;
            ok <= 1'b1;
          end
          else
          begin
            state <= icache_pkg::CTRL_REFILL;
            victim_q <= victim_way;
          end
        icache_pkg::CTRL_REFILL:
          if (line_full)
            state <= icache_pkg::CTRL_INSTALL;
        icache_pkg::CTRL_INSTALL:
        begin
          state <= icache_pkg::CTRL_REPLY;
          ok <= 1'b1;
        end
        default:
          state <= icache_pkg::CTRL_IDLE;
      endcase
    end
  end

  // Address captured on the way into LOOKUP
  always_ff @(posedge clk)
  begin
    if (state == icache_pkg::CTRL_IDLE && req)
    begin
      req_line <= icache_pkg::line_addr_t'(insaddr[`ICACHE_WORD_W-1 -: LINE_ADDR_W]);
      req_off <= insaddr[BYTE_W +: `ICACHE_OFF_W];
    end
  end

  // Returned word, from the store on a hit or straight from the fill buffer
  always_ff @(posedge clk)
  begin
    if (state == icache_pkg::CTRL_LOOKUP && hit)
      ins <= read_line[req_off];
    else if (state == icache_pkg::CTRL_INSTALL)
      ins <= fill_line[req_off];
  end

  assign lookup_idx = req_line.index;
  assign lookup_tag = req_line.tag;

  assign refill_start = (state == icache_pkg::CTRL_LOOKUP) && !hit;
  assign refill_line = req_line;

  assign install = (state == icache_pkg::CTRL_INSTALL);
  assign install_way = victim_q;
  assign install_line_addr = req_line;
  assign install_data = fill_line;
  assign line_take = install;

  assign touch = install || ((state == icache_pkg::CTRL_LOOKUP) && hit);
  assign touch_way = install ? victim_q : hit_way;

endmodule

`default_nettype wire

// ==== src/icache_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_store (
  input  wire logic               clk,
  input  wire logic               rst,
  input  icache_pkg::index_t      lookup_idx,
  input  icache_pkg::tag_t        lookup_tag,
  output logic                    hit,
  output icache_pkg::way_t        hit_way,
  output icache_pkg::way_t        victim_way,
  output icache_pkg::line_t       read_line,
  input  wire logic               install,
  input  icache_pkg::way_t        install_way,
  input  icache_pkg::line_addr_t  install_line_addr,
  input  icache_pkg::line_t       install_data,
  input  wire logic               touch,
  input  icache_pkg::way_t        touch_way
);

  icache_pkg::tag_t      tags [`ICACHE_WAYS][`ICACHE_SETS];
  icache_pkg::line_t     data [`ICACHE_WAYS][`ICACHE_SETS];
  icache_pkg::way_mask_t valid [`ICACHE_SETS];
  icache_pkg::age_t      ages [`ICACHE_SETS][`ICACHE_WAYS];

  icache_pkg::way_mask_t hit_mask;
  icache_pkg::age_t      touch_age;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup and victim choice
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    hit_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--)
    begin
      hit_mask[w] = valid[lookup_idx][w] && (tags[w][lookup_idx] == lookup_tag);
      if (hit_mask[w])
        hit_way = icache_pkg::way_t'(w);
    end
  end

  assign hit = |hit_mask;
  assign read_line = data[hit_way][lookup_idx];

  // Lowest invalid way wins, else oldest with ties to the low way
  always_comb
  begin
    icache_pkg::way_t best;
    best = '0;
    for (int w = 1; w < `ICACHE_WAYS; w++)
      if (ages[lookup_idx][w] > ages[lookup_idx][best])
        best = icache_pkg::way_t'(w);
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--)
      if (!valid[lookup_idx][w])
        best = icache_pkg::way_t'(w);
    victim_way = best;
  end

  // An empty way counts as the oldest one
  assign touch_age = valid[lookup_idx][touch_way] ? ages[lookup_idx][touch_way] : '1;

  ////////////////////////////////////////////////////////////////////////////
  // Array updates
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
      begin
        valid[s] <= '0;
        for (int w = 0; w < `ICACHE_WAYS; w++)
          ages[s][w] <= '0;
      end
    end
    else
    begin
      if (install)
        valid[install_line_addr.index][install_way] <= 1'b1;
      if (touch)
        for (int w = 0; w < `ICACHE_WAYS; w++)
          if (icache_pkg::way_t'(w) == touch_way)
            ages[lookup_idx][w] <= '0;
          else if (ages[lookup_idx][w] < touch_age)
            ages[lookup_idx][w] <= ages[lookup_idx][w] + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (install)
    begin
      tags[install_way][install_line_addr.index] <= install_line_addr.tag;
      data[install_way][install_line_addr.index] <= install_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_refill (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               refill_start,
  input  icache_pkg::line_addr_t  refill_line,
  output logic                    sen,
  output icache_pkg::word_t       addr,
  input  wire logic               data_ok,
  input  icache_pkg::word_t       sdata,
  output logic                    fill_valid,
  output icache_pkg::fill_word_t  fill_word
);

  localparam int LOW_W = `ICACHE_WORD_W - $bits(icache_pkg::line_addr_t);
  localparam icache_pkg::offset_t LAST_OFF = icache_pkg::offset_t'(`ICACHE_LINE_WORDS - 1);

  icache_pkg::refill_state_t state;
  icache_pkg::offset_t       offset;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= icache_pkg::RF_IDLE;
      offset <= '0;
      addr <= '0;
    end
    else
    begin
      case (state)
        icache_pkg::RF_IDLE:
          if (refill_start)
          begin
            state <= icache_pkg::RF_FETCH;
            offset <= '0;
            // Line base, word and byte bits zero
            addr <= {refill_line, {LOW_W{1'b0}}};
          end
        default:
          if (data_ok)
          begin
            offset <= offset + 1'b1;
            if (offset == LAST_OFF)
              state <= icache_pkg::RF_IDLE;
          end
      endcase
    end
  end

  assign sen = (state == icache_pkg::RF_FETCH);

  // One word forwarded per strobe
  assign fill_valid = sen && data_ok;
  assign fill_word.offset = offset;
  assign fill_word.data = sdata;

endmodule

`default_nettype wire

// ==== src/icache_fill_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_fill_buf (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               fill_valid,
  input  icache_pkg::fill_word_t  fill_word,
  output logic                    line_full,
  output icache_pkg::line_t       fill_line,
  input  wire logic               line_take
);

  localparam logic [`ICACHE_OFF_W:0] FULL_COUNT = `ICACHE_LINE_WORDS;

  // Words held so far, 0 to 16
  logic [`ICACHE_OFF_W:0] count;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      count <= '0;
    else if (line_take)
      count <= '0;
    else if (fill_valid)
      count <= count + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (fill_valid)
      fill_line[fill_word.offset] <= fill_word.data;
  end

  assign line_full = (count == FULL_COUNT);

endmodule

`default_nettype wire

// ==== src/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             req,
  input  icache_pkg::word_t     insaddr,
  output icache_pkg::word_t     ins,
  output logic                  ok,
  output logic                  sen,
  output icache_pkg::word_t     addr,
  input  wire logic             data_ok,
  input  icache_pkg::word_t     sdata
);

  logic                   refill_start;
  icache_pkg::line_addr_t refill_line;
  logic                   fill_valid;
  icache_pkg::fill_word_t fill_word;
  logic                   line_full;
  icache_pkg::line_t      fill_line;
  logic                   line_take;

  icache_pkg::index_t     lookup_idx;
  icache_pkg::tag_t       lookup_tag;
  logic                   hit;
  icache_pkg::way_t       hit_way;
  icache_pkg::way_t       victim_way;
  icache_pkg::line_t      read_line;
  logic                   install;
  icache_pkg::way_t       install_way;
  icache_pkg::line_addr_t install_line_addr;
  icache_pkg::line_t      install_data;
  logic                   touch;
  icache_pkg::way_t       touch_way;

  icache_ctrl icache_ctrl_i (
    .clk, .rst, .req, .insaddr, .ins, .ok,
    .refill_start, .refill_line,
    .line_full, .fill_line, .line_take,
    .lookup_idx, .lookup_tag, .hit, .hit_way, .victim_way, .read_line,
    .install, .install_way, .install_line_addr, .install_data,
    .touch, .touch_way
  );

  icache_store icache_store_i (
    .clk, .rst,
    .lookup_idx, .lookup_tag, .hit, .hit_way, .victim_way, .read_line,
    .install, .install_way, .install_line_addr, .install_data,
    .touch, .touch_way
  );

  icache_refill icache_refill_i (
    .clk, .rst, .refill_start, .refill_line,
    .sen, .addr, .data_ok, .sdata,
    .fill_valid, .fill_word
  );

  icache_fill_buf icache_fill_buf_i (
    .clk, .rst, .fill_valid, .fill_word,
    .line_full, .fill_line, .line_take
  );

endmodule

`default_nettype wire

// ==== test/icache_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_chk (
  input wire logic         clk,
  input wire logic         rst,
  input wire logic         ok,
  input wire logic         sen,
  input wire logic         data_ok,
  input icache_pkg::word_t addr
);

  // Strobes seen in the current refill
  logic [4:0]  strobes;
  int unsigned fail_count = 0;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      strobes <= '0;
    else if (!sen)
      strobes <= '0;
    else if (data_ok)
      strobes <= strobes + 1'b1;
  end

  ok_single: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else
    begin
      fail_count++;
      $error("ok high for two cycles in a row");
    end

  sen_hold: assert property (@(posedge clk) disable iff (rst)
      sen && !(data_ok && strobes == 5'd15) |=> sen)
    else
    begin
      fail_count++;
      $error("sen dropped before the sixteenth data_ok");
    end

  ok_not_in_refill: assert property (@(posedge clk) disable iff (rst) !(ok && sen))
    else
    begin
      fail_count++;
      $error("ok raised during a refill");
    end

  addr_aligned: assert property (@(posedge clk) disable iff (rst) sen |-> addr[5:0] == 6'd0)
    else
    begin
      fail_count++;
      $error("refill addr not line aligned");
    end

endmodule

bind icache_top icache_chk icache_chk_i (.*);

`default_nettype wire

// ==== test/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_tb;

  localparam time CLK_PERIOD = 20ns;
  localparam int RESET_CYCLES = 10;
  localparam int RAND_REQS = 200;
  // 1 cold + 1 hit + 16 line + 10 LRU + random
  localparam int NUM_REQS = 28 + RAND_REQS;
  localparam icache_pkg::word_t MEM_KEY = 32'h5a5a_0000;
  localparam logic [31:0] SEED = 32'heb3e;
  localparam icache_pkg::tag_t LINE_TAG = 22'h0_1234;
  localparam icache_pkg::tag_t LRU_TAG = 22'h0_0100;
  localparam icache_pkg::tag_t RAND_TAG = 22'h0_2000;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              req = 1'b0;
  icache_pkg::word_t insaddr = '0;
  icache_pkg::word_t ins;
  logic              ok;
  logic              sen;
  icache_pkg::word_t addr;
  logic              data_ok = 1'b0;
  icache_pkg::word_t sdata = '0;

  // Per-request expectations
  logic req_start = 1'b0;
  logic exp_hit = 1'b0;
  logic sen_seen = 1'b0;

  int errors = 0;
  int requests = 0;
  int tests = 0;
  int test_base = 0;

  // Reference tag, valid and age state
  icache_pkg::tag_t m_tag [`ICACHE_SETS][`ICACHE_WAYS];
  logic             m_valid [`ICACHE_SETS][`ICACHE_WAYS];
  icache_pkg::age_t m_age [`ICACHE_SETS][`ICACHE_WAYS];

  logic [31:0] stim_seed = SEED;
  logic [31:0] mem_seed = SEED;
  logic [1:0]  gap = 2'd0;
  int          mem_words = 0;

  icache_top icache_top_i (
    .clk, .rst, .req, .insaddr, .ins, .ok,
    .sen, .addr, .data_ok, .sdata
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic icache_pkg::word_t mem_word(input icache_pkg::word_t a);
    return {a[`ICACHE_WORD_W-1:2], 2'b00} ^ MEM_KEY;
  endfunction

  function automatic icache_pkg::word_t make_addr(input icache_pkg::tag_t tag,
      input icache_pkg::index_t idx, input icache_pkg::offset_t off, input logic [1:0] lane);
    return {tag, idx, off, lane};
  endfunction

  function automatic int total_errors();
    return errors + icache_top_i.icache_chk_i.fail_count;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst)
    begin
      data_ok <= 1'b0;
      mem_words <= 0;
    end
    else
    begin
      data_ok <= 1'b0;
      if (!sen)
        mem_words <= 0;
      else if (mem_words < `ICACHE_LINE_WORDS)
      begin
        if (gap == 2'd0)
        begin
          data_ok <= 1'b1;
          sdata <= mem_word(addr + 4 * mem_words);
          mem_words <= mem_words + 1;
          gap <= mem_seed[17:16];
          mem_seed <= lcg_next(mem_seed);
        end
        else
          gap <= gap - 1'b1;
      end
    end
  end

  // Did this request start a refill
  always @(posedge clk)
  begin
    if (req_start)
      sen_seen <= 1'b0;
    else if (sen)
      sen_seen <= 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  word_match: assert property (@(posedge clk) disable iff (rst) ok |-> ins == mem_word(insaddr))
    else
    begin
      errors++;
      $display("Fail %0t: ins %h for insaddr %h", $time, $sampled(ins), $sampled(insaddr));
    end

  refill_match: assert property (@(posedge clk) disable iff (rst) ok |-> sen_seen == !exp_hit)
    else
    begin
      errors++;
      $display("Fail %0t: refill %0b for insaddr %h, expected %0b", $time,
        $sampled(sen_seen), $sampled(insaddr), !$sampled(exp_hit));
    end

  hit_timing: assert property (@(posedge clk) disable iff (rst)
      req_start && exp_hit |-> ##1 !ok ##1 ok ##1 !ok)
    else
    begin
      errors++;
      $display("Fail %0t: hit reply not on the second edge", $time);
    end

  line_base: assert property (@(posedge clk) disable iff (rst)
      sen |-> addr == {insaddr[`ICACHE_WORD_W-1:6], 6'b0})
    else
    begin
      errors++;
      $display("Fail %0t: refill addr %h for insaddr %h", $time,
        $sampled(addr), $sampled(insaddr));
    end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and request tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_access(input icache_pkg::word_t a, output logic was_hit);
    icache_pkg::tag_t   tag;
    icache_pkg::index_t idx;
    icache_pkg::age_t   old_age;
    logic               found;
    int                 way;
    begin
      tag = a[`ICACHE_WORD_W-1 -: `ICACHE_TAG_W];
      idx = a[2+`ICACHE_OFF_W +: `ICACHE_IDX_W];
      was_hit = 1'b0;
      found = 1'b0;
      way = 0;
      for (int w = 0; w < `ICACHE_WAYS; w++)
        if (!was_hit && m_valid[idx][w] && m_tag[idx][w] == tag)
        begin
          was_hit = 1'b1;
          way = w;
        end
      // First empty way, else the oldest
      if (!was_hit)
      begin
        for (int w = 0; w < `ICACHE_WAYS; w++)
          if (!found && !m_valid[idx][w])
          begin
            found = 1'b1;
            way = w;
          end
        if (!found)
          for (int w = 1; w < `ICACHE_WAYS; w++)
            if (m_age[idx][w] > m_age[idx][way])
              way = w;
      end
      old_age = m_valid[idx][way] ? m_age[idx][way] : 2'd3;
      for (int w = 0; w < `ICACHE_WAYS; w++)
        if (w == way)
          m_age[idx][w] = 2'd0;
        else if (m_age[idx][w] < old_age)
          m_age[idx][w] = m_age[idx][w] + 1'b1;
      m_valid[idx][way] = 1'b1;
      m_tag[idx][way] = tag;
    end
  endtask

  task automatic access(input icache_pkg::word_t a, input logic check, input logic want_hit);
    logic hit_pred;
    begin
      model_access(a, hit_pred);
      if (check)
        assert (hit_pred == want_hit)
        else
        begin
          errors++;
          $display("Fail %0t: hit %0b predicted for %h, expected %0b", $time,
            hit_pred, a, want_hit);
        end
      req <= 1'b1;
      insaddr <= a;
      req_start <= 1'b1;
      exp_hit <= hit_pred;
      requests++;
      @(posedge clk);
      req_start <= 1'b0;
      do
        @(posedge clk);
      while (!ok);
    end
  endtask

  task automatic finish_test(input string name);
    int now_errors;
    begin
      req <= 1'b0;
      repeat (2) @(posedge clk);
      now_errors = total_errors();
      $display("%-10s done, %0d errors", name, now_errors - test_base);
      test_base = now_errors;
      tests++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    icache_pkg::word_t a;
    logic [31:0]       r;
    int                total;
    for (int s = 0; s < `ICACHE_SETS; s++)
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        m_valid[s][w] = 1'b0;
        m_age[s][w] = 2'd0;
        m_tag[s][w] = '0;
      end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    a = make_addr(LINE_TAG, 4'd2, 4'd7, 2'd1);
    access(a, 1'b1, 1'b0);
    finish_test("cold_miss");

    access(a, 1'b1, 1'b1);
    finish_test("hit");

    for (int o = 0; o < `ICACHE_LINE_WORDS; o++)
      access(make_addr(LINE_TAG, 4'd2, o[3:0], 2'd0), 1'b1, 1'b1);
    finish_test("line_fill");

    // A, B, C, D then A again, so B is the oldest when E comes
    for (int t = 0; t < 4; t++)
      access(make_addr(icache_pkg::tag_t'(LRU_TAG + t), 4'd5, t[3:0], 2'd0), 1'b1, 1'b0);
    access(make_addr(LRU_TAG, 4'd5, 4'd9, 2'd0), 1'b1, 1'b1);
    access(make_addr(icache_pkg::tag_t'(LRU_TAG + 4), 4'd5, 4'd3, 2'd0), 1'b1, 1'b0);
    access(make_addr(LRU_TAG, 4'd5, 4'd1, 2'd0), 1'b1, 1'b1);
    access(make_addr(icache_pkg::tag_t'(LRU_TAG + 2), 4'd5, 4'd2, 2'd0), 1'b1, 1'b1);
    access(make_addr(icache_pkg::tag_t'(LRU_TAG + 3), 4'd5, 4'd4, 2'd0), 1'b1, 1'b1);
    access(make_addr(icache_pkg::tag_t'(LRU_TAG + 1), 4'd5, 4'd6, 2'd0), 1'b1, 1'b0);
    finish_test("lru_evict");

    for (int n = 0; n < RAND_REQS; n++)
    begin
      stim_seed = lcg_next(stim_seed);
      r = stim_seed;
      a = make_addr(icache_pkg::tag_t'(RAND_TAG + r[18:16]), {r[21:20], 2'b01},
        r[25:22], r[27:26]);
      access(a, 1'b0, 1'b0);
    end
    finish_test("random");

    total = total_errors();
    $display("tests %0d, requests %0d, errors %0d", tests, requests, total);
    if (total == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Worst case refill plus overhead for every request
  initial
  begin
    #((NUM_REQS * (16 * 4 + 10) + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout, the cache stopped answering requests");
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/icache_pkg.sv
src/icache_ctrl.sv
src/icache_store.sv
src/icache_refill.sv
src/icache_fill_buf.sv
src/icache_top.sv
test/icache_chk.sv
test/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - src
    files:
      - src/icache_pkg.sv
      - src/icache_ctrl.sv
      - src/icache_store.sv
      - src/icache_refill.sv
      - src/icache_fill_buf.sv
      - src/icache_top.sv
      - target: test
        files:
          - test/icache_chk.sv
          - test/icache_tb.sv
